// File: sources.f
prbs_pkg.sv
lfsr.sv
prbs_checker.sv
prbs_top.sv
prbs_checker_props.sv
prbs_tb.sv

// File: Makefile
# Verilator build and run of the PRBS link tester testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps
TOP       := prbs_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
PASS_MSG  := TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"

# Status of the pipeline is the status of grep
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: prbs_tb.sv
/*
 * Testbench of the PRBS link tester
 * Clock, reset, external loopback with bit-flip and garbage corruption
 * Reference model of the generator and of the checker lock FSM
 * Per-cycle output checks, scenario checks and watchdog
 */

module prbs_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import prbs_pkg::*;

	localparam int unsigned DATA_W       = DEF_DATA_W;
	localparam int unsigned SEED         = DEF_SEED;
	localparam int unsigned LOCK_COUNT   = DEF_LOCK_COUNT;
	localparam int unsigned UNLOCK_COUNT = DEF_UNLOCK_COUNT;
	localparam int unsigned ERR_CNT_W    = DEF_ERR_CNT_W;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 2;
	localparam int N_RANDOM     = 200;
	localparam int N_CLEAN      = 300;
	localparam int N_SETTLE     = 16;
	localparam int TOTAL_CYCLES = RESET_CYCLES + N_RANDOM + N_CLEAN + 2 * N_SETTLE
		+ UNLOCK_COUNT + LOCK_COUNT + 2;

	// Loopback corruption modes
	localparam int MODE_CLEAN   = 0;
	localparam int MODE_FLIP    = 1;
	localparam int MODE_GARBAGE = 2;

	// XNOR maximal-length tap masks, bit n-1 set for tap n, widths 3 to 32
	localparam logic [31:0] TAP_MASKS [3:32] = '{
		32'h6,        32'hC,        32'h14,       32'h30,       32'h60,       32'hB8,
		32'h110,      32'h240,      32'h500,      32'h829,      32'h100D,     32'h2015,
		32'h6000,     32'hD008,     32'h12000,    32'h20400,    32'h40023,    32'h90000,
		32'h140000,   32'h300000,   32'h420000,   32'hE10000,   32'h1200000,  32'h2000023,
		32'h4000013,  32'h9000000,  32'h14000000, 32'h20000029, 32'h48000000, 32'h80200003
	};

	logic                 clk_i;
	logic                 reset_n_i;
	logic                 gen_en_i;
	logic                 rx_valid_i;
	logic [DATA_W-1:0]    rx_data_i;
	logic [DATA_W-1:0]    tx_data_o;
	logic                 locked_o;
	logic                 err_o;
	logic [ERR_CNT_W-1:0] err_count_o;

	// Model state
	logic [DATA_W-1:0]    gen_model;
	logic [DATA_W-1:0]    prev_word;
	logic                 have_prev;
	logic                 m_locked;
	logic                 exp_err;
	logic                 prev_en;
	logic [ERR_CNT_W-1:0] exp_count;
	int                   match_run;
	int                   miss_run;
	int                   err_pulses;
	logic [31:0]          rng_state = 32'd39283;

	prbs_top #(
		.DATA_W       (DATA_W),
		.SEED         (SEED),
		.LOCK_COUNT   (LOCK_COUNT),
		.UNLOCK_COUNT (UNLOCK_COUNT),
		.ERR_CNT_W    (ERR_CNT_W)
	) u_dut (
		.clk_i       (clk_i),
		.reset_n_i   (reset_n_i),
		.gen_en_i    (gen_en_i),
		.rx_valid_i  (rx_valid_i),
		.rx_data_i   (rx_data_i),
		.tx_data_o   (tx_data_o),
		.locked_o    (locked_o),
		.err_o       (err_o),
		.err_count_o (err_count_o)
	);

	bind prbs_checker prbs_checker_props #(
		.LOCK_COUNT (LOCK_COUNT),
		.ERR_CNT_W  (ERR_CNT_W)
	) u_props (
		.clk_i        (clk_i),
		.reset_n_i    (reset_n_i),
		.state_i      (state_q),
		.cmp_vld_i    (cmp_vld),
		.word_match_i (word_match),
		.locked_i     (locked_o),
		.err_i        (err_o),
		.err_count_i  (err_count_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------

	// One XNOR step, feedback enters at bit 0
	function automatic logic [DATA_W-1:0] lfsr_step(input logic [DATA_W-1:0] s);
		logic [31:0] taps;
		logic        fb;
		taps = TAP_MASKS[DATA_W];
		fb   = 1'b1;
		for (int i = 0; i < DATA_W; i++) begin
			if (taps[i])
				fb = fb ^ s[i];
		end
		return {s[DATA_W-2:0], fb};
	endfunction

	// LCG
	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic report_failure(input string what);
		$display("Error: %s", what);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	// Advance generator and checker models by one clock edge
	task automatic update_model(input logic en, input logic valid,
		input logic [DATA_W-1:0] data);
		logic hit;
		exp_err = 1'b0;
		if (en)
			gen_model = lfsr_step(gen_model);
		if (valid && have_prev) begin
			hit = (data == lfsr_step(prev_word));
			if (!m_locked) begin
				// Misses in HUNT restart the run, nothing is counted
				match_run = hit ? match_run + 1 : 0;
				if (match_run == LOCK_COUNT) begin
					m_locked = 1'b1;
					miss_run = 0;
				end
			end else if (!hit) begin
				exp_err = 1'b1;
				if (exp_count != '1)
					exp_count = exp_count + 1'b1;
				miss_run++;
				if (miss_run == UNLOCK_COUNT) begin
					m_locked  = 1'b0;
					match_run = 0;
				end
			end else begin
				miss_run = 0;
			end
		end
		if (valid) begin
			have_prev = 1'b1;
			prev_word = data;
		end
	endtask

	task automatic check_outputs();
		assert (tx_data_o === gen_model)
			else report_mismatch("tx_data_o", 32'(tx_data_o), 32'(gen_model));
		assert (tx_data_o !== '1)
			else report_failure("generator reached the all-ones lock-up state");
		assert (locked_o === m_locked)
			else report_mismatch("locked_o", 32'(locked_o), 32'(m_locked));
		assert (err_o === exp_err)
			else report_mismatch("err_o", 32'(err_o), 32'(exp_err));
		assert (err_count_o === exp_count)
			else report_mismatch("err_count_o", 32'(err_count_o), 32'(exp_count));
	endtask

	// Loopback word is the current transmit word, valid is last cycle's enable
	task automatic run_cycle(input logic en, input int mode);
		logic              valid;
		logic [DATA_W-1:0] data;
		valid = prev_en;
		data  = tx_data_o;
		if (valid && mode == MODE_FLIP)
			data = data ^ (DATA_W'(1) << (next_random() % DATA_W));
		else if (valid && mode == MODE_GARBAGE)
			data = DATA_W'(next_random() >> 8);
		gen_en_i   = en;
		rx_valid_i = valid;
		rx_data_i  = data;
		@(posedge clk_i);
		#1;
		update_model(en, valid, data);
		check_outputs();
		if (err_o)
			err_pulses++;
		prev_en = en;
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------

	initial begin
		logic [ERR_CNT_W-1:0] count_before;
		reset_n_i  = 1'b0;
		gen_en_i   = 1'b0;
		rx_valid_i = 1'b0;
		rx_data_i  = '0;
		gen_model  = DATA_W'(SEED);
		prev_word  = '0;
		have_prev  = 1'b0;
		m_locked   = 1'b0;
		exp_err    = 1'b0;
		prev_en    = 1'b0;
		exp_count  = '0;
		match_run  = 0;
		miss_run   = 0;
		err_pulses = 0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		#1;
		reset_n_i = 1'b1;
		check_outputs();

		// Generator with random idle cycles, first lock happens here
		for (int n = 0; n < N_RANDOM; n++)
			run_cycle((next_random() % 4) != 0, MODE_CLEAN);

		// Long clean run
		for (int n = 0; n < N_CLEAN; n++)
			run_cycle(1'b1, MODE_CLEAN);
		assert (locked_o && err_count_o == '0)
			else report_failure("clean loopback lost lock or counted errors");

		// One flipped bit gives two bad compares
		count_before = exp_count;
		err_pulses   = 0;
		run_cycle(1'b1, MODE_FLIP);
		repeat (N_SETTLE) run_cycle(1'b1, MODE_CLEAN);
		assert (err_pulses == 2)
			else report_mismatch("err_o pulse count", 32'(err_pulses), 32'd2);
		assert (err_count_o == count_before + ERR_CNT_W'(2))
			else report_mismatch("err_count_o", 32'(err_count_o), 32'(count_before) + 2);
		assert (locked_o)
			else report_failure("single bit error dropped the lock");

		// Garbage burst, lock loss and recovery
		count_before = exp_count;
		repeat (UNLOCK_COUNT) run_cycle(1'b1, MODE_GARBAGE);
		assert (!locked_o)
			else report_failure("checker stayed locked through the garbage burst");
		repeat (LOCK_COUNT + 1) run_cycle(1'b1, MODE_CLEAN);
		assert (locked_o)
			else report_failure("checker did not relock on clean words");
		assert (err_count_o == count_before + ERR_CNT_W'(UNLOCK_COUNT))
			else report_mismatch("err_count_o", 32'(err_count_o),
				32'(count_before) + UNLOCK_COUNT);
		repeat (N_SETTLE) run_cycle(1'b1, MODE_CLEAN);

		if (u_dut.u_checker.u_props.fail_cnt == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			report_failure("concurrent property checks failed");
		end
	end

	// Watchdog
	initial begin
		#((TOTAL_CYCLES + 100) * CLK_PERIOD);
		report_failure("watchdog timeout, the test sequence did not finish");
	end

endmodule

// File: prbs_checker_props.sv
/*
 * Concurrent checks on the PRBS checker, attached to prbs_checker by bind
 * Error strobe only after a LOCKED cycle, error counter never decreases
 * Lock entry only after a full run of consecutive matches
 */

module prbs_checker_props #(
	parameter int unsigned LOCK_COUNT = prbs_pkg::DEF_LOCK_COUNT,
	parameter int unsigned ERR_CNT_W  = prbs_pkg::DEF_ERR_CNT_W
) (
	input logic                  clk_i,
	input logic                  reset_n_i,
	input prbs_pkg::lock_state_e state_i,
	input logic                  cmp_vld_i,
	input logic                  word_match_i,
	input logic                  locked_i,
	input logic                  err_i,
	input logic [ERR_CNT_W-1:0]  err_count_i
);

	timeunit 1ns;
	timeprecision 100ps;

	import prbs_pkg::*;

	// Number of failed properties, read by the testbench at the end
	int unsigned fail_cnt = 0;

	// Matching compares in a row while unlocked
	int unsigned match_seen;

	always_ff @(posedge clk_i or negedge reset_n_i) begin
		if (!reset_n_i)
			match_seen <= 0;
		else if (locked_i)
			match_seen <= 0;
		else if (cmp_vld_i)
			match_seen <= word_match_i ? match_seen + 1 : 0;
	end

	// Strobe only for a word compared in LOCKED
	assert property (@(posedge clk_i) disable iff (!reset_n_i)
		err_i |-> $past(state_i) == LOCKED)
		else begin
			fail_cnt++;
			$error("err_o high although the checker was in HUNT");
		end

	// Counter only grows or saturates
	assert property (@(posedge clk_i) disable iff (!reset_n_i)
		err_count_i >= $past(err_count_i))
		else begin
			fail_cnt++;
			$error("err_count_o decreased");
		end

	// Lock taken right after the LOCK_COUNT-th consecutive match
	assert property (@(posedge clk_i) disable iff (!reset_n_i)
		$rose(locked_i) |-> match_seen == LOCK_COUNT)
		else begin
			fail_cnt++;
			$error("locked_o rose before a full run of matches");
		end

endmodule

// File: prbs_top.sv
/*
 * PRBS link tester top level
 * Generator LFSR driving the transmit word
 * Sequence checker on the looped-back receive word
 */

module prbs_top #(
	parameter int unsigned DATA_W       = prbs_pkg::DEF_DATA_W,
	parameter int unsigned SEED         = prbs_pkg::DEF_SEED,
	parameter int unsigned LOCK_COUNT   = prbs_pkg::DEF_LOCK_COUNT,
	parameter int unsigned UNLOCK_COUNT = prbs_pkg::DEF_UNLOCK_COUNT,
	parameter int unsigned ERR_CNT_W    = prbs_pkg::DEF_ERR_CNT_W
) (
	input  logic                 clk_i,
	input  logic                 reset_n_i,
	input  logic                 gen_en_i,
	input  logic                 rx_valid_i,
	input  logic [DATA_W-1:0]    rx_data_i,
	output logic [DATA_W-1:0]    tx_data_o,
	output logic                 locked_o,
	output logic                 err_o,
	output logic [ERR_CNT_W-1:0] err_count_o
);

	// ------------------------------------------------------------------------
	// Generator
	// ------------------------------------------------------------------------

	// Free-running from the seed, never loaded
	lfsr #(
		.DATA_W (DATA_W),
		.SEED   (SEED)
	) u_gen_lfsr (
		.clk_i      (clk_i),
		.reset_n_i  (reset_n_i),
		.step_i     (gen_en_i),
		.load_i     (1'b0),
		.load_dat_i ('0),
		.lfsr_dat_o (tx_data_o),
		.next_dat_o ()
	);

	// ------------------------------------------------------------------------
	// Checker
	// ------------------------------------------------------------------------

	prbs_checker #(
		.DATA_W       (DATA_W),
		.LOCK_COUNT   (LOCK_COUNT),
		.UNLOCK_COUNT (UNLOCK_COUNT),
		.ERR_CNT_W    (ERR_CNT_W)
	) u_checker (
		.clk_i       (clk_i),
		.reset_n_i   (reset_n_i),
		.rx_valid_i  (rx_valid_i),
		.rx_data_i   (rx_data_i),
		.locked_o    (locked_o),
		.err_o       (err_o),
		.err_count_o (err_count_o)
	);

endmodule

// File: prbs_checker.sv
/*
 * Self-synchronizing PRBS checker
 * One-step predictor LFSR reloaded from every received word
 * HUNT/LOCKED FSM with match and mismatch run counters
 * Error strobe and saturating error counter, active only while LOCKED
 */

module prbs_checker #(
	parameter int unsigned DATA_W       = prbs_pkg::DEF_DATA_W,
	parameter int unsigned LOCK_COUNT   = prbs_pkg::DEF_LOCK_COUNT,
	parameter int unsigned UNLOCK_COUNT = prbs_pkg::DEF_UNLOCK_COUNT,
	parameter int unsigned ERR_CNT_W    = prbs_pkg::DEF_ERR_CNT_W
) (
	input  logic                 clk_i,
	input  logic                 reset_n_i,
	input  logic                 rx_valid_i,
	input  logic [DATA_W-1:0]    rx_data_i,
	output logic                 locked_o,
	output logic                 err_o,
	output logic [ERR_CNT_W-1:0] err_count_o
);

	import prbs_pkg::*;

	localparam int unsigned MATCH_W = $clog2(LOCK_COUNT + 1);
	localparam int unsigned MISS_W  = $clog2(UNLOCK_COUNT + 1);

	// ------------------------------------------------------------------------
	// Predictor
	// ------------------------------------------------------------------------

	logic [DATA_W-1:0] expect_dat;

	// Holds the last received word, its successor is the expected next word
	// Reset value is never compared, a word must arrive first
	lfsr #(
		.DATA_W (DATA_W),
		.SEED   (0)
	) u_ref_lfsr (
		.clk_i      (clk_i),
		.reset_n_i  (reset_n_i),
		.step_i     (1'b0),
		.load_i     (rx_valid_i),
		.load_dat_i (rx_data_i),
		.lfsr_dat_o (),
		.next_dat_o (expect_dat)
	);

	logic have_prev_q;
	logic cmp_vld;
	logic word_match;

	assign cmp_vld    = rx_valid_i && have_prev_q;
	assign word_match = (rx_data_i == expect_dat);

	// ------------------------------------------------------------------------
	// Lock FSM and error counting
	// ------------------------------------------------------------------------

	lock_state_e          state_q, state_d;
	logic [MATCH_W-1:0]   match_run_q, match_run_d;
	logic [MISS_W-1:0]    miss_run_q, miss_run_d;
	logic                 err_q, err_d;
	logic [ERR_CNT_W-1:0] err_count_q, err_count_d;

	always_comb begin
		state_d     = state_q;
		match_run_d = match_run_q;
		miss_run_d  = miss_run_q;
		err_d       = 1'b0;
		err_count_d = err_count_q;
		if (cmp_vld) begin
			case (state_q)
				HUNT: begin
					// Mismatches here only restart the run
					if (!word_match) begin
						match_run_d = '0;
					end else if (match_run_q == MATCH_W'(LOCK_COUNT - 1)) begin
						state_d     = LOCKED;
						match_run_d = '0;
						miss_run_d  = '0;
					end else begin
						match_run_d = match_run_q + 1'b1;
					end
				end
				LOCKED: begin
					if (word_match) begin
						miss_run_d = '0;
					end else begin
						err_d = 1'b1;
						// Saturate at all ones
						if (err_count_q != '1)
							err_count_d = err_count_q + 1'b1;
						if (miss_run_q == MISS_W'(UNLOCK_COUNT - 1)) begin
							state_d    = HUNT;
							miss_run_d = '0;
						end else begin
							miss_run_d = miss_run_q + 1'b1;
						end
					end
				end
				default: state_d = HUNT;
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge reset_n_i) begin
		if (!reset_n_i) begin
			have_prev_q <= 1'b0;
			state_q     <= HUNT;
			match_run_q <= '0;
			miss_run_q  <= '0;
			err_q       <= 1'b0;
			err_count_q <= '0;
		end else begin
			// First valid word only primes the predictor
			if (rx_valid_i)
				have_prev_q <= 1'b1;
			state_q     <= state_d;
			match_run_q <= match_run_d;
			miss_run_q  <= miss_run_d;
			err_q       <= err_d;
			err_count_q <= err_count_d;
		end
	end

	assign locked_o    = (state_q == LOCKED);
	assign err_o       = err_q;
	assign err_count_o = err_count_q;

endmodule

// File: lfsr.sv
/*
 * XNOR Fibonacci LFSR for widths 3 to 32
 * Maximal-length tap table, step enable and synchronous load
 * Registered state output and combinational one-step successor
 */

module lfsr #(
	parameter int unsigned DATA_W = prbs_pkg::DEF_DATA_W,
	parameter int unsigned SEED   = prbs_pkg::DEF_SEED
) (
	input  logic              clk_i,
	input  logic              reset_n_i,
	input  logic              step_i,
	input  logic              load_i,
	input  logic [DATA_W-1:0] load_dat_i,
	output logic [DATA_W-1:0] lfsr_dat_o,
	output logic [DATA_W-1:0] next_dat_o
);

	// ------------------------------------------------------------------------
	// Tap table
	// ------------------------------------------------------------------------

	// Mask bit for a tap given in 1-based notation, 0 means no tap
	function automatic logic [31:0] tap_bit(input int unsigned pos);
		return (pos == 0) ? 32'd0 : (32'd1 << (pos - 1));
	endfunction

	// Maximal-length XNOR taps per width, 1-based like the usual tables
	function automatic logic [31:0] tap_mask(input int unsigned width);
		case (width)
			3:  return tap_bit(3)  | tap_bit(2);
			4:  return tap_bit(4)  | tap_bit(3);
			5:  return tap_bit(5)  | tap_bit(3);
			6:  return tap_bit(6)  | tap_bit(5);
			7:  return tap_bit(7)  | tap_bit(6);
			8:  return tap_bit(8)  | tap_bit(6)  | tap_bit(5)  | tap_bit(4);
			9:  return tap_bit(9)  | tap_bit(5);
			10: return tap_bit(10) | tap_bit(7);
			11: return tap_bit(11) | tap_bit(9);
			12: return tap_bit(12) | tap_bit(6)  | tap_bit(4)  | tap_bit(1);
			13: return tap_bit(13) | tap_bit(4)  | tap_bit(3)  | tap_bit(1);
			14: return tap_bit(14) | tap_bit(5)  | tap_bit(3)  | tap_bit(1);
			15: return tap_bit(15) | tap_bit(14);
			16: return tap_bit(16) | tap_bit(15) | tap_bit(13) | tap_bit(4);
			17: return tap_bit(17) | tap_bit(14);
			18: return tap_bit(18) | tap_bit(11);
			19: return tap_bit(19) | tap_bit(6)  | tap_bit(2)  | tap_bit(1);
			20: return tap_bit(20) | tap_bit(17);
			21: return tap_bit(21) | tap_bit(19);
			22: return tap_bit(22) | tap_bit(21);
			23: return tap_bit(23) | tap_bit(18);
			24: return tap_bit(24) | tap_bit(23) | tap_bit(22) | tap_bit(17);
			25: return tap_bit(25) | tap_bit(22);
			26: return tap_bit(26) | tap_bit(6)  | tap_bit(2)  | tap_bit(1);
			27: return tap_bit(27) | tap_bit(5)  | tap_bit(2)  | tap_bit(1);
			28: return tap_bit(28) | tap_bit(25);
			29: return tap_bit(29) | tap_bit(27);
			30: return tap_bit(30) | tap_bit(6)  | tap_bit(4)  | tap_bit(1);
			31: return tap_bit(31) | tap_bit(28);
			32: return tap_bit(32) | tap_bit(22) | tap_bit(2)  | tap_bit(1);
			default: return 32'd0;
		endcase
	endfunction

	localparam logic [31:0]       TAP_TABLE = tap_mask(DATA_W);
	localparam logic [DATA_W-1:0] TAP_MASK  = TAP_TABLE[DATA_W-1:0];
	localparam logic [DATA_W-1:0] SEED_VAL  = DATA_W'(SEED);

	// ------------------------------------------------------------------------
	// Step and state register
	// ------------------------------------------------------------------------

	logic [DATA_W-1:0] state_q;
	logic              feedback;

	// Untapped bits are masked to zero so they do not disturb the parity
	assign feedback   = ~^(state_q & TAP_MASK);

	// Shift up by one, feedback enters at bit 0
	assign next_dat_o = {state_q[DATA_W-2:0], feedback};
	assign lfsr_dat_o = state_q;

	// Load has priority over step
	always_ff @(posedge clk_i or negedge reset_n_i) begin
		if (!reset_n_i) begin
			state_q <= SEED_VAL;
		end else if (load_i) begin
			state_q <= load_dat_i;
		end else if (step_i) begin
			state_q <= next_dat_o;
		end
	end

endmodule

// File: prbs_pkg.sv
/*
 * Shared package of the PRBS link tester
 * Checker lock state type
 * Default word width, generator seed, lock thresholds and counter width
 */

package prbs_pkg;

	// ------------------------------------------------------------------------
	// Checker state
	// ------------------------------------------------------------------------

	// HUNT while searching for the sequence, LOCKED once it is tracked
	typedef enum logic {
		HUNT   = 1'b0,
		LOCKED = 1'b1
	} lock_state_e;

	// ------------------------------------------------------------------------
	// Default configuration
	// ------------------------------------------------------------------------

	// Word width, legal range 3 to 32
	parameter int unsigned DEF_DATA_W       = 16;

	// Generator seed, all ones is the XNOR lock-up state and is illegal
	parameter int unsigned DEF_SEED         = 2;

	// Consecutive matches needed in HUNT to enter LOCKED
	parameter int unsigned DEF_LOCK_COUNT   = 4;

	// Consecutive mismatches in LOCKED that drop back to HUNT
	parameter int unsigned DEF_UNLOCK_COUNT = 3;

	// Error counter width
	parameter int unsigned DEF_ERR_CNT_W    = 16;

endpackage
